// File: flist.f
rtl/periph_pkg.sv
rtl/periph_sel_if.sv
rtl/bus_decode.sv
rtl/gpio_regs.sv
rtl/byte_reg_bank.sv
rtl/read_return.sv
rtl/pin_func_mux.sv
rtl/periph_top.sv
bench/tb_periph.sv

// File: Makefile
# Verilator build and run for the peripheral register wrapper

VERILATOR ?= verilator
TOP       ?= tb_periph
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
FAIL_MSG  ?= >>> FAIL

.PHONY: help build test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

build:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

test: build
	@./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q -F -e '$(FAIL_MSG)' $(LOG) || [ $$status -ne 0 ]; then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: bench/tb_periph.sv
// Directed testbench for the peripheral register wrapper against a reference model
`timescale 1ns/10ps

module tb_periph;
    import periph_pkg::*;

    localparam int SEED           = 73625;
    localparam int RESET_CYCLES   = 5;
    // About 300 accesses at up to 4 cycles each, plus margin
    localparam int TIMEOUT_CYCLES = 2000;
    localparam int READY_LIMIT    = 8;

    logic    clk;
    logic    rst_n;
    byte_t   ui_in;
    addr_t   addr;
    word_t   wdata;
    access_t write_n;
    access_t read_n;
    logic    read_complete;
    byte_t   uo_out;
    word_t   rdata;
    logic    data_ready;

    // Reference model of the register state
    byte_t     gpio_out_model;
    byte_t     byte_model [NUM_BYTE_REGS];
    func_sel_t func_sel_model [NUM_PINS];

    int error_count = 0;
    int check_count = 0;
    int cycle_count = 0;

    periph_top UUT (
        .clk             (clk),
        .rst_n           (rst_n),
        .i_ui_in         (ui_in),
        .i_addr          (addr),
        .i_wdata         (wdata),
        .i_write_n       (write_n),
        .i_read_n        (read_n),
        .i_read_complete (read_complete),
        .o_uo_out        (uo_out),
        .o_rdata         (rdata),
        .o_data_ready    (data_ready)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: tests still running after %0d cycles", TIMEOUT_CYCLES);
            $display("Checks: %0d, errors: %0d", check_count, error_count);
            $display(">>> FAIL");
            $finish;
        end
    end

    task automatic compare_value(input string name, input word_t got, input word_t expected);
        check_count++;
        assert (got === expected)
        else begin
            error_count++;
            $display("FAIL t=%0t %s: expected 0x%08h, got 0x%08h", $time, name, expected, got);
        end
    endtask

    task automatic expect_true(input logic cond, input string what);
        check_count++;
        assert (cond)
        else begin
            error_count++;
            $display("ERROR t=%0t %s", $time, what);
        end
    endtask

    // Address map: bit 10 simple slots (slot in 7:4), else user slot in 9:6
    function automatic addr_t user_addr(input logic [3:0] slot, input offset_t off);
        return {1'b0, slot, off};
    endfunction

    function automatic addr_t bank_addr(input logic [3:0] slot, input logic [3:0] off);
        return {1'b1, 2'b00, slot, off};
    endfunction

    function automatic addr_t func_sel_addr(input int pin);
        return user_addr(SLOT_GPIO, OFF_FUNC_SEL_BASE | offset_t'(pin * 4));
    endfunction

    // Pin i takes bit i of the source its select names, else zero
    function automatic byte_t expected_pins();
        byte_t     pins;
        func_sel_t sel;
        pins = '0;
        for (int i = 0; i < NUM_PINS; i++) begin
            sel = func_sel_model[i];
            if (sel[4] && sel[3:0] < 4'(NUM_BYTE_REGS)) begin
                pins[i] = byte_model[sel[1:0]][i];
            end else if (!sel[4] && sel[3:0] == SLOT_GPIO) begin
                pins[i] = gpio_out_model[i];
            end
        end
        return pins;
    endfunction

    task automatic check_pins();
        compare_value("o_uo_out", word_t'(uo_out), word_t'(expected_pins()));
    endtask

    // Any size code other than idle counts as a write
    task automatic bus_write(input addr_t a, input word_t data);
        @(negedge clk);
        addr    = a;
        wdata   = data;
        write_n = access_t'($urandom_range(2, 0));
        // Write ready shows in the same cycle, before the capturing edge
        #1;
        compare_value("o_data_ready", word_t'(data_ready), 32'd1);
        @(negedge clk);
        write_n = ACCESS_NONE;
    endtask

    task automatic bus_read(input addr_t a, input word_t expected);
        int waited;
        @(negedge clk);
        addr   = a;
        read_n = access_t'($urandom_range(2, 0));
        waited = 0;
        // Read ready is registered and stays low until the next rising edge
        #1;
        compare_value("o_data_ready", word_t'(data_ready), 32'd0);
        do begin
            @(negedge clk);
            waited++;
        end while (!data_ready && waited < READY_LIMIT);
        if (!data_ready) begin
            expect_true(1'b0, $sformatf("no data ready for read at 0x%03h", a));
        end else begin
            expect_true(waited == 1, $sformatf("data ready came %0d cycles after read", waited));
            compare_value($sformatf("o_rdata @0x%03h", a), rdata, expected);
        end
        read_n        = ACCESS_NONE;
        read_complete = 1'b1;
        @(negedge clk);
        read_complete = 1'b0;
        // Ready is a single-cycle pulse
        compare_value("o_data_ready", word_t'(data_ready), 32'd0);
    endtask

    task automatic set_gpio_out(input word_t data);
        bus_write(user_addr(SLOT_GPIO, OFF_GPIO_OUT), data);
        gpio_out_model = data[7:0];
    endtask

    task automatic write_byte_reg(input int k, input word_t data);
        bus_write(bank_addr(4'(k), 4'h0), data);
        byte_model[k] = data[7:0];
    endtask

    task automatic set_func_sel(input int pin, input func_sel_t sel);
        word_t data;
        data      = $urandom;
        data[4:0] = sel;
        bus_write(func_sel_addr(pin), data);
        func_sel_model[pin] = sel;
    endtask

    task automatic verify_reset_state();
        compare_value("o_uo_out", word_t'(uo_out), 32'd0);
        for (int i = 0; i < NUM_PINS; i++) begin
            bus_read(func_sel_addr(i), word_t'(FUNC_SEL_RESET));
        end
        bus_read(user_addr(SLOT_GPIO, OFF_GPIO_OUT), 32'd0);
        for (int k = 0; k < NUM_BYTE_REGS; k++) begin
            bus_read(bank_addr(4'(k), 4'h0), 32'd0);
        end
    endtask

    task automatic exercise_gpio();
        byte_t pins;
        for (int n = 0; n < 8; n++) begin
            set_gpio_out($urandom);
            check_pins();
            bus_read(user_addr(SLOT_GPIO, OFF_GPIO_OUT), word_t'(gpio_out_model));
            pins  = byte_t'($urandom);
            ui_in = pins;
            bus_read(user_addr(SLOT_GPIO, OFF_GPIO_IN), word_t'(pins));
        end
        // Input offset is read only, gaps in the map read zero
        bus_write(user_addr(SLOT_GPIO, OFF_GPIO_IN), 32'hffff_ffff);
        bus_read(user_addr(SLOT_GPIO, 6'h08), 32'd0);
        bus_read(user_addr(SLOT_GPIO, 6'h1c), 32'd0);
        bus_read(user_addr(SLOT_GPIO, OFF_GPIO_OUT), word_t'(gpio_out_model));
        check_pins();
    endtask

    task automatic exercise_byte_bank();
        for (int n = 0; n < 6; n++) begin
            for (int k = 0; k < NUM_BYTE_REGS; k++) begin
                write_byte_reg(k, $urandom);
            end
            for (int k = 0; k < NUM_BYTE_REGS; k++) begin
                bus_read(bank_addr(4'(k), 4'h0), word_t'(byte_model[k]));
            end
            check_pins();
        end
        for (int s = NUM_BYTE_REGS; s < 16; s++) begin
            bus_write(bank_addr(4'(s), 4'h0), $urandom);
            bus_read(bank_addr(4'(s), 4'h0), 32'd0);
        end
        for (int k = 0; k < NUM_BYTE_REGS; k++) begin
            bus_write(bank_addr(4'(k), 4'h8), $urandom);
            bus_read(bank_addr(4'(k), 4'h4), 32'd0);
        end
        for (int s = 0; s < 16; s++) begin
            if (4'(s) != SLOT_GPIO) begin
                bus_read(user_addr(4'(s), 6'h00), 32'd0);
            end
        end
        // Writes to unmapped locations must not have touched the bank
        for (int k = 0; k < NUM_BYTE_REGS; k++) begin
            bus_read(bank_addr(4'(k), 4'h0), word_t'(byte_model[k]));
        end
    endtask

    task automatic remap_pin_functions();
        set_gpio_out(32'h0000_00ff);
        for (int k = 0; k < NUM_BYTE_REGS; k++) begin
            write_byte_reg(k, $urandom);
        end
        for (int i = 0; i < NUM_PINS; i++) begin
            for (int k = 0; k < NUM_BYTE_REGS; k++) begin
                set_func_sel(i, {1'b1, 4'(k)});
                compare_value($sformatf("o_uo_out[%0d]", i), word_t'(uo_out[i]),
                              word_t'(byte_model[k][i]));
                check_pins();
            end
            bus_read(func_sel_addr(i), word_t'(func_sel_model[i]));
            // Unpopulated bank slot and unpopulated user slot
            set_func_sel(i, {1'b1, 4'd9});
            compare_value($sformatf("o_uo_out[%0d]", i), word_t'(uo_out[i]), 32'd0);
            set_func_sel(i, {1'b0, 4'd5});
            compare_value($sformatf("o_uo_out[%0d]", i), word_t'(uo_out[i]), 32'd0);
            set_func_sel(i, FUNC_SEL_RESET);
            check_pins();
        end
        // All pins spread over the bank at once
        for (int i = 0; i < NUM_PINS; i++) begin
            set_func_sel(i, {1'b1, 4'(i % NUM_BYTE_REGS)});
        end
        for (int n = 0; n < 4; n++) begin
            write_byte_reg(n, $urandom);
            check_pins();
        end
    endtask

    task automatic probe_read_handshake();
        byte_t first;
        first = byte_t'($urandom);
        write_byte_reg(0, word_t'(first));
        set_gpio_out(word_t'(first ^ 8'h5a));
        @(negedge clk);
        compare_value("o_data_ready", word_t'(data_ready), 32'd0);
        addr   = bank_addr(4'h0, 4'h0);
        read_n = 2'd2;
        @(negedge clk);
        compare_value("o_data_ready", word_t'(data_ready), 32'd1);
        compare_value("o_rdata", rdata, word_t'(first));
        // Read dropped but not yet completed, so the value stays held
        read_n = ACCESS_NONE;
        @(negedge clk);
        compare_value("o_data_ready", word_t'(data_ready), 32'd0);
        wdata   = word_t'(~first);
        write_n = 2'd2;
        @(negedge clk);
        compare_value("o_data_ready", word_t'(data_ready), 32'd1);
        compare_value("o_rdata", rdata, word_t'(first));
        write_n       = ACCESS_NONE;
        byte_model[0] = ~first;
        addr          = user_addr(SLOT_GPIO, OFF_GPIO_OUT);
        read_n        = 2'd2;
        @(negedge clk);
        compare_value("o_rdata", rdata, word_t'(first));
        read_n        = ACCESS_NONE;
        read_complete = 1'b1;
        @(negedge clk);
        read_complete = 1'b0;
        bus_read(bank_addr(4'h0, 4'h0), word_t'(byte_model[0]));
        bus_read(user_addr(SLOT_GPIO, OFF_GPIO_OUT), word_t'(gpio_out_model));
    endtask

    initial begin
        void'($urandom(SEED));
        rst_n          = 1'b0;
        ui_in          = '0;
        addr           = '0;
        wdata          = '0;
        write_n        = ACCESS_NONE;
        read_n         = ACCESS_NONE;
        read_complete  = 1'b0;
        gpio_out_model = '0;
        for (int k = 0; k < NUM_BYTE_REGS; k++) begin
            byte_model[k] = '0;
        end
        for (int i = 0; i < NUM_PINS; i++) begin
            func_sel_model[i] = FUNC_SEL_RESET;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        verify_reset_state();
        exercise_gpio();
        exercise_byte_bank();
        remap_pin_functions();
        probe_read_handshake();

        @(negedge clk);
        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// File: rtl/periph_top.sv
// Peripheral register wrapper top level joining decode, registers and read return
`timescale 1ns/10ps

module periph_top (
    input  logic                clk,
    input  logic                rst_n,
    input  periph_pkg::byte_t   i_ui_in,
    input  periph_pkg::addr_t   i_addr,
    input  periph_pkg::word_t   i_wdata,
    input  periph_pkg::access_t i_write_n,
    input  periph_pkg::access_t i_read_n,
    input  logic                i_read_complete,
    output periph_pkg::byte_t   o_uo_out,
    output periph_pkg::word_t   o_rdata,
    output logic                o_data_ready
);
    import periph_pkg::*;

    read_src_t                 read_src;
    byte_t                     gpio_out;
    func_sel_t [NUM_PINS-1:0]  func_sel;
    word_t                     gpio_rdata;
    byte_t [NUM_BYTE_REGS-1:0] bank_regs;
    byte_t                     bank_rdata;

    periph_sel_if gpio_bus ();
    periph_sel_if bank_bus ();

    bus_decode u_bus_decode (
        .i_addr     (i_addr),
        .i_wdata    (i_wdata),
        .i_write_n  (i_write_n),
        .i_read_n   (i_read_n),
        .o_read_src (read_src),
        .gpio_bus   (gpio_bus.decoder),
        .bank_bus   (bank_bus.decoder)
    );

    gpio_regs u_gpio_regs (
        .clk        (clk),
        .rst_n      (rst_n),
        .i_ui_in    (i_ui_in),
        .o_gpio_out (gpio_out),
        .o_func_sel (func_sel),
        .o_rdata    (gpio_rdata),
        .bus        (gpio_bus.target)
    );

    // Simple slot index is address bits 7:4
    byte_reg_bank u_byte_reg_bank (
        .clk     (clk),
        .rst_n   (rst_n),
        .i_slot  (i_addr[7:4]),
        .o_regs  (bank_regs),
        .o_rdata (bank_rdata),
        .bus     (bank_bus.target)
    );

    read_return u_read_return (
        .clk             (clk),
        .rst_n           (rst_n),
        .i_read_n        (i_read_n),
        .i_write_n       (i_write_n),
        .i_read_complete (i_read_complete),
        .i_read_src      (read_src),
        .i_gpio_rdata    (gpio_rdata),
        .i_bank_rdata    (bank_rdata),
        .o_rdata         (o_rdata),
        .o_data_ready    (o_data_ready)
    );

    pin_func_mux u_pin_func_mux (
        .i_func_sel  (func_sel),
        .i_gpio_out  (gpio_out),
        .i_bank_regs (bank_regs),
        .o_uo_out    (o_uo_out)
    );

endmodule

// File: rtl/pin_func_mux.sv
// Per-pin output multiplexer steered by the GPIO function selects
`timescale 1ns/10ps

module pin_func_mux (
    input  periph_pkg::func_sel_t [periph_pkg::NUM_PINS-1:0]  i_func_sel,
    input  periph_pkg::byte_t                                  i_gpio_out,
    input  periph_pkg::byte_t [periph_pkg::NUM_BYTE_REGS-1:0] i_bank_regs,
    output periph_pkg::byte_t                                  o_uo_out
);
    import periph_pkg::*;

    for (genvar i = 0; i < NUM_PINS; i++) begin : g_pin
        logic       use_bank;
        logic [3:0] slot;

        assign use_bank = i_func_sel[i][4];
        assign slot     = i_func_sel[i][3:0];

        always_comb begin
            if (use_bank) begin
                if (slot < NUM_BYTE_REGS) begin
                    o_uo_out[i] = i_bank_regs[slot[BYTE_IDX_BITS-1:0]][i];
                end else begin
                    o_uo_out[i] = 1'b0;
                end
            end else if (slot == SLOT_GPIO) begin
                o_uo_out[i] = i_gpio_out[i];
            end else begin
                // Unpopulated user slot
                o_uo_out[i] = 1'b0;
            end
        end
    end

endmodule

// File: rtl/read_return.sv
// Read data return path with a holding register and data-ready generation
`timescale 1ns/10ps

module read_return (
    input  logic                  clk,
    input  logic                  rst_n,
    input  periph_pkg::access_t   i_read_n,
    input  periph_pkg::access_t   i_write_n,
    input  logic                  i_read_complete,
    input  periph_pkg::read_src_t i_read_src,
    input  periph_pkg::word_t     i_gpio_rdata,
    input  periph_pkg::byte_t     i_bank_rdata,
    output periph_pkg::word_t     o_rdata,
    output logic                  o_data_ready
);
    import periph_pkg::*;

    logic  rd_req;
    logic  hold;
    logic  ready_r;
    word_t rd_value;
    word_t rdata_r;

    assign rd_req = (i_read_n != ACCESS_NONE);

    always_comb begin
        case (i_read_src)
            GPIO:      rd_value = i_gpio_rdata;
            BYTE_BANK: rd_value = word_t'(i_bank_rdata);
            default:   rd_value = '0;
        endcase
    end

    // Capture once per read and keep it until the core is done with it
    always_ff @(posedge clk) begin
        if (!hold && rd_req) begin
            rdata_r <= rd_value;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hold    <= 1'b0;
            ready_r <= 1'b0;
        end else begin
            if (i_read_complete) begin
                hold <= 1'b0;
            end
            if (!hold && rd_req) begin
                hold <= 1'b1;
            end
            // Single pulse, the core drops its read once it sees ready
            ready_r <= rd_req && !ready_r;
        end
    end

    assign o_rdata      = rdata_r;
    // Writes complete in the cycle they are presented
    assign o_data_ready = ready_r || (i_write_n != ACCESS_NONE);

    a_hold_stable : assert property (
        @(posedge clk) disable iff (!rst_n)
        hold && !i_read_complete |=> $stable(rdata_r)
    ) else $error("read_return: held read data changed before read complete");

endmodule

// File: rtl/byte_reg_bank.sv
// Bank of byte registers occupying the first simple peripheral slots
`timescale 1ns/10ps

module byte_reg_bank (
    input  logic                                               clk,
    input  logic                                               rst_n,
    input  logic [3:0]                                         i_slot,
    output periph_pkg::byte_t [periph_pkg::NUM_BYTE_REGS-1:0] o_regs,
    output periph_pkg::byte_t                                  o_rdata,
    periph_sel_if.target                                       bus
);
    import periph_pkg::*;

    byte_t [NUM_BYTE_REGS-1:0] regs;
    logic                      slot_hit;
    logic                      wr_en;
    logic [BYTE_IDX_BITS-1:0]  idx;

    // Only offset 0 of the low slots is backed by a register
    assign slot_hit = (i_slot < NUM_BYTE_REGS) && (bus.offset == '0);
    assign idx      = i_slot[BYTE_IDX_BITS-1:0];
    assign wr_en    = bus.sel && bus.wr && slot_hit;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            regs <= '0;
        end else if (wr_en) begin
            regs[idx] <= bus.wdata[7:0];
        end
    end

    assign o_rdata = slot_hit ? regs[idx] : '0;
    assign o_regs  = regs;

    // Pin outputs may only move after a decoded write
    a_regs_need_write : assert property (
        @(posedge clk) disable iff (!rst_n)
        !(bus.sel && bus.wr) |=> $stable(regs)
    ) else $error("byte_reg_bank: register changed without a write");

endmodule

// File: rtl/gpio_regs.sv
// GPIO output register, input readback and per-pin function select registers
`timescale 1ns/10ps

module gpio_regs (
    input  logic                                              clk,
    input  logic                                              rst_n,
    input  periph_pkg::byte_t                                 i_ui_in,
    output periph_pkg::byte_t                                 o_gpio_out,
    output periph_pkg::func_sel_t [periph_pkg::NUM_PINS-1:0] o_func_sel,
    output periph_pkg::word_t                                 o_rdata,
    periph_sel_if.target                                      bus
);
    import periph_pkg::*;

    byte_t                    gpio_out;
    func_sel_t [NUM_PINS-1:0] func_sel;
    logic                     wr_en;
    logic                     func_hit;
    logic [2:0]               func_idx;

    assign wr_en = bus.sel && bus.wr;

    // Function selects sit one word apart, pin index in offset bits 4:2
    assign func_idx = bus.offset[4:2];
    assign func_hit = (bus.offset & ~offset_t'(6'h1c)) == OFF_FUNC_SEL_BASE;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            gpio_out <= '0;
        end else if (wr_en && bus.offset == OFF_GPIO_OUT) begin
            gpio_out <= bus.wdata[7:0];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            func_sel <= {NUM_PINS{FUNC_SEL_RESET}};
        end else if (wr_en && func_hit) begin
            func_sel[func_idx] <= bus.wdata[4:0];
        end
    end

    // Readback, zero-extended to the bus width
    always_comb begin
        if (bus.offset == OFF_GPIO_OUT) begin
            o_rdata = word_t'(gpio_out);
        end else if (bus.offset == OFF_GPIO_IN) begin
            o_rdata = word_t'(i_ui_in);
        end else if (func_hit) begin
            o_rdata = word_t'(func_sel[func_idx]);
        end else begin
            o_rdata = '0;
        end
    end

    assign o_gpio_out = gpio_out;
    assign o_func_sel = func_sel;

endmodule

// File: rtl/bus_decode.sv
// Address decoder steering core accesses to the GPIO block or the byte bank
`timescale 1ns/10ps

module bus_decode (
    input  periph_pkg::addr_t     i_addr,
    input  periph_pkg::word_t     i_wdata,
    input  periph_pkg::access_t   i_write_n,
    input  periph_pkg::access_t   i_read_n,
    output periph_pkg::read_src_t o_read_src,
    periph_sel_if.decoder         gpio_bus,
    periph_sel_if.decoder         bank_bus
);
    import periph_pkg::*;

    logic       is_simple;
    logic [3:0] user_slot;
    logic       gpio_sel;
    logic       bank_sel;
    logic       write_cyc;

    // Bit 10 splits simple byte slots from the 16 user slots
    assign is_simple = i_addr[10];
    assign user_slot = i_addr[9:6];

    assign gpio_sel  = !is_simple && (user_slot == SLOT_GPIO);
    assign bank_sel  = is_simple;
    assign write_cyc = (i_write_n != ACCESS_NONE);

    assign gpio_bus.sel    = gpio_sel;
    assign gpio_bus.offset = i_addr[5:0];
    assign gpio_bus.wr     = write_cyc;
    assign gpio_bus.wdata  = i_wdata;

    // Simple slots are 16 bytes wide, slot index comes from bits 7:4
    assign bank_bus.sel    = bank_sel;
    assign bank_bus.offset = offset_t'(i_addr[3:0]);
    assign bank_bus.wr     = write_cyc;
    assign bank_bus.wdata  = i_wdata;

    always_comb begin
        o_read_src = NONE;
        if (i_read_n != ACCESS_NONE) begin
            if (gpio_sel) begin
                o_read_src = GPIO;
            end else if (bank_sel) begin
                o_read_src = BYTE_BANK;
            end
        end
    end

    // Both register blocks must never see the same access
    always_comb begin
        assert ($onehot0({gpio_sel, bank_sel}))
            else $error("bus_decode: GPIO and byte bank selected together");
    end

endmodule

// File: rtl/periph_sel_if.sv
// Decoded register access from the address decoder to one register block
`timescale 1ns/10ps

interface periph_sel_if;
    import periph_pkg::*;

    // Block select, already qualified by the address
    logic    sel;
    offset_t offset;
    // High in every cycle that carries a write
    logic    wr;
    word_t   wdata;

    modport decoder (
        output sel,
        output offset,
        output wr,
        output wdata
    );

    modport target (
        input  sel,
        input  offset,
        input  wr,
        input  wdata
    );

endinterface

// File: rtl/periph_pkg.sv
// Peripheral wrapper package with the address map, bus widths and shared types
package periph_pkg;

    // Bus and pin widths
    typedef logic [10:0] addr_t;
    typedef logic [31:0] word_t;
    typedef logic [7:0]  byte_t;
    typedef logic [5:0]  offset_t;

    // Top bit picks the byte bank, low four bits pick the slot
    typedef logic [4:0]  func_sel_t;

    // 0 byte, 1 halfword, 2 word, 3 idle
    typedef logic [1:0]  access_t;

    // Which block answers a read
    typedef enum logic [1:0] {
        NONE,
        GPIO,
        BYTE_BANK
    } read_src_t;

    localparam access_t ACCESS_NONE = 2'b11;

    // User slot holding the GPIO block
    localparam logic [3:0] SLOT_GPIO = 4'd1;

    localparam int NUM_PINS      = 8;
    localparam int NUM_BYTE_REGS = 4;
    localparam int BYTE_IDX_BITS = $clog2(NUM_BYTE_REGS);

    // GPIO register offsets
    localparam offset_t OFF_GPIO_OUT      = 6'h00;
    localparam offset_t OFF_GPIO_IN       = 6'h04;
    localparam offset_t OFF_FUNC_SEL_BASE = 6'h20;

    // Every pin starts out driven from the GPIO output register
    localparam func_sel_t FUNC_SEL_RESET = {1'b0, SLOT_GPIO};

endpackage
